// ==== dv/eth_tx_dma_assertions.sv ====
`timescale 1ns/1ps

module eth_tx_dma_assertions (
  input logic clk_i,
  input logic arst_i,
  input logic arvalid_i,
  input logic arready_i,
  input logic bd_wen_i,
  input logic send_i,
  input logic tx_irq_i
);

  // Number of failed assertions
  int unsigned fail_count = 0;

  arvalid_held: assert property (@(posedge clk_i) disable iff (arst_i)
    arvalid_i && !arready_i |=> arvalid_i)
  else begin
    fail_count++;
    $error("arvalid dropped before arready");
  end

  // Write-back only happens once the transmitter has the frame
  no_wen_during_send: assert property (@(posedge clk_i) disable iff (arst_i)
    !(bd_wen_i && send_i))
  else begin
    fail_count++;
    $error("bd_wen high while send high");
  end

  irq_one_cycle: assert property (@(posedge clk_i) disable iff (arst_i)
    tx_irq_i |=> !tx_irq_i)
  else begin
    fail_count++;
    $error("tx_irq longer than one cycle");
  end

  irq_with_wen: assert property (@(posedge clk_i) disable iff (arst_i)
    tx_irq_i |-> bd_wen_i)
  else begin
    fail_count++;
    $error("tx_irq without status write");
  end

endmodule

bind eth_tx_dma_top eth_tx_dma_assertions u_eth_tx_dma_assertions (
  .clk_i     (clk_i),
  .arst_i    (arst_i),
  .arvalid_i (axi_arvalid_o),
  .arready_i (axi_arready_i),
  .bd_wen_i  (bd_wen_o),
  .send_i    (send_o),
  .tx_irq_i  (tx_irq_o)
);

// ==== dv/tb_eth_tx_dma.sv ====
`timescale 1ns/1ps

`include "eth_dma_params.svh"

module tb_eth_tx_dma;

  import eth_dma_pkg::*;

  localparam int N_FRAMES   = 12;
  localparam int MAX_LEN    = 64;
  localparam int MAX_BURST  = `ETH_MAX_BURST;
  localparam int CLK_NS     = 4;
  localparam int WRAP_IDX   = 4;
  localparam int TIMEOUT_NS = N_FRAMES * (MAX_LEN * 8 + 200) * CLK_NS;

  logic                       clk;
  logic                       arst;
  logic [`ETH_BD_ADDR_W-1:0]  bd_addr;
  logic                       bd_wen;
  logic [31:0]                bd_wdata;
  logic [31:0]                bd_rdata;
  logic [`ETH_AXI_ADDR_W-1:0] araddr;
  logic [`ETH_AXI_LEN_W-1:0]  arlen;
  logic                       arvalid;
  logic                       arready;
  logic [`ETH_AXI_DATA_W-1:0] rdata;
  logic                       rvalid;
  logic                       rlast;
  logic                       rready;
  logic                       buf_wen;
  logic [`ETH_BUFFER_W-1:0]   buf_addr;
  logic [7:0]                 buf_wdata;
  logic                       send;
  logic                       crc_en;
  logic [10:0]                tx_nbytes;
  logic                       tx_ready;
  logic                       tx_en;
  logic                       tx_irq;

  integer seed = 32'h641fd7d8;

  // Models and expected frames
  logic [31:0]               desc_mem [0:255];
  logic [7:0]                fbuf [0:2047];
  int                        f_len [N_FRAMES];
  logic [31:0]               f_ptr [N_FRAMES];
  bd_word_u                  f_ctrl [N_FRAMES];
  bd_num_t                   f_idx [N_FRAMES];
  logic [`ETH_BD_ADDR_W-1:0] bd_addr_q;
  logic [31:0]               beat_addr;
  logic                      armed;
  logic                      rd_active;
  logic                      sent;
  logic                      send_prev;
  int                        beats_left;
  int                        req_bytes;
  int                        got_bytes;
  int                        done_count;
  int                        irq_seen;
  int                        tx_phase;
  int                        tx_cnt;

  eth_tx_dma_top u_eth_tx_dma_top (
    .clk_i         (clk),
    .arst_i        (arst),
    .bd_addr_o     (bd_addr),
    .bd_wen_o      (bd_wen),
    .bd_wdata_o    (bd_wdata),
    .bd_rdata_i    (bd_rdata),
    .axi_araddr_o  (araddr),
    .axi_arlen_o   (arlen),
    .axi_arvalid_o (arvalid),
    .axi_arready_i (arready),
    .axi_rdata_i   (rdata),
    .axi_rvalid_i  (rvalid),
    .axi_rlast_i   (rlast),
    .axi_rready_o  (rready),
    .buf_wen_o     (buf_wen),
    .buf_addr_o    (buf_addr),
    .buf_wdata_o   (buf_wdata),
    .send_o        (send),
    .crc_en_o      (crc_en),
    .tx_nbytes_o   (tx_nbytes),
    .tx_ready_i    (tx_ready),
    .tx_en_i       (tx_en),
    .tx_irq_o      (tx_irq)
  );

  always #(CLK_NS / 2) clk = ~clk;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "run stopped");
  endtask

  task automatic check_equal(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      stop_with_failure($sformatf("mismatch %s expected %0h actual %0h", name, exp, act));
    end
  endtask

  // External memory fill that depends on every address bit
  function automatic logic [7:0] ext_byte(input logic [31:0] addr);
    ext_byte = addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ addr[31:24] ^ {addr[2:0], addr[7:3]};
  endfunction

  // Outputs sampled at the rising edge before the DUT updates
  always @(posedge clk) begin : monitor
    int          k;
    int          remain;
    logic [31:0] exp_addr;
    bd_word_u    exp_status;

    bd_addr_q = bd_addr;
    k         = done_count;
    if (!arst) begin
      if (u_eth_tx_dma_top.u_eth_tx_dma_assertions.fail_count != 0) begin
        stop_with_failure("a bound protocol assertion failed");
      end
      if (buf_wen) begin
        fbuf[buf_addr] = buf_wdata;
      end
      if (tx_irq) begin
        irq_seen++;
      end
      // Reader takes data in every data-phase cycle
      if (rd_active) begin
        check_equal("rready", 1, rready);
      end
      if (arvalid && !armed) begin
        stop_with_failure("AR request issued while no BD was ready and enabled");
      end
      // Burst shape follows from the bytes still to fetch
      if (arvalid && arready) begin
        remain   = f_len[k] - req_bytes;
        exp_addr = f_ptr[k] + req_bytes;
        check_equal("ar_addr", exp_addr, araddr);
        check_equal("ar_len", ((remain > MAX_BURST) ? MAX_BURST : remain) - 1, arlen);
        beat_addr  = araddr;
        beats_left = arlen + 1;
        req_bytes  = req_bytes + beats_left;
        rd_active  = 1'b1;
      end
      if (rvalid && rready) begin
        got_bytes++;
        beat_addr++;
        beats_left--;
        rd_active = (beats_left != 0);
      end
      if (send && !send_prev) begin
        check_equal("tx_nbytes", f_len[k] + `ETH_PRE_FRAME_LEN, tx_nbytes);
        check_equal("crc_en", f_ctrl[k].ctrl.crc_en, crc_en);
        check_equal("beat_total", f_len[k], got_bytes);
        for (int i = 0; i < f_len[k]; i++) begin
          check_equal("payload", ext_byte(f_ptr[k] + i), fbuf[`ETH_PRE_FRAME_LEN + i]);
          fbuf[`ETH_PRE_FRAME_LEN + i] = 'x;
        end
        sent = 1'b1;
      end
      if (bd_wen) begin
        if (!sent) begin
          stop_with_failure("status written back before the frame was sent");
        end
        exp_status            = f_ctrl[k];
        exp_status.ctrl.ready = 1'b0;
        check_equal("bd_wb_addr", {f_idx[k], 1'b0}, bd_addr);
        check_equal("bd_wb_data", exp_status.raw, bd_wdata);
        check_equal("tx_irq", f_ctrl[k].ctrl.irq_en, tx_irq);
        desc_mem[bd_addr] = bd_wdata;
        sent       = 1'b0;
        req_bytes  = 0;
        got_bytes  = 0;
        done_count = done_count + 1;
      end
    end
    send_prev = send;
  end

  // BD read data, AXI slave and transmitter driven on the falling edge
  always @(negedge clk) begin
    bd_rdata = desc_mem[bd_addr_q];
    arready  = !rd_active && (($random(seed) & 3) != 0);
    rvalid   = rd_active && (($random(seed) & 3) != 0);
    rlast    = rd_active && (beats_left == 1);
    rdata    = $random(seed);
    rdata[beat_addr[1:0]*8 +: 8] = ext_byte(beat_addr);
    case (tx_phase)
      0: begin
        if (send === 1'b1) begin
          tx_cnt   = 1 + ($unsigned($random(seed)) % 5);
          tx_phase = 1;
        end
      end
      1: begin
        tx_cnt--;
        if (tx_cnt == 0) begin
          tx_ready = 1'b0;
          tx_cnt   = 2 + ($unsigned($random(seed)) % 6);
          tx_phase = 2;
        end
      end
      default: begin
        tx_cnt--;
        if (tx_cnt == 0) begin
          tx_ready = 1'b1;
          tx_phase = 0;
        end
      end
    endcase
  end

  initial begin
    #(TIMEOUT_NS);
    stop_with_failure("timeout, DMA stopped making progress");
  end

  initial begin
    int       len;
    int       gap;
    int       exp_irq;
    bd_num_t  idx;
    bd_word_u ctrl;
    logic     hold_en;

    clk        = 1'b0;
    arst       = 1'b1;
    tx_en      = 1'b1;
    tx_ready   = 1'b1;
    bd_rdata   = '0;
    arready    = 1'b0;
    rdata      = '0;
    rvalid     = 1'b0;
    rlast      = 1'b0;
    armed      = 1'b0;
    rd_active  = 1'b0;
    sent       = 1'b0;
    send_prev  = 1'b0;
    beat_addr  = '0;
    beats_left = 0;
    req_bytes  = 0;
    got_bytes  = 0;
    done_count = 0;
    irq_seen   = 0;
    tx_phase   = 0;
    tx_cnt     = 0;
    exp_irq    = 0;
    idx        = '0;
    for (int i = 0; i < 256; i++) begin
      desc_mem[i] = '0;
    end

    repeat (16) @(negedge clk);
    arst = 1'b0;
    @(negedge clk);
    check_equal("idle_send", 0, send);
    check_equal("idle_bd_wen", 0, bd_wen);
    check_equal("idle_arvalid", 0, arvalid);
    check_equal("idle_irq", 0, tx_irq);

    // Pre-frame takes eight cycles after reset
    repeat (10) @(negedge clk);
    for (int i = 0; i < `ETH_PRE_FRAME_LEN; i++) begin
      check_equal("preframe", (i == `ETH_PREAMBLE_LEN) ? `ETH_SFD : `ETH_PREAMBLE, fbuf[i]);
    end

    for (int k = 0; k < N_FRAMES; k++) begin
      len      = 1 + ($unsigned($random(seed)) % MAX_LEN);
      ctrl.raw = $random(seed);
      ctrl.ctrl.frame_len = 16'(len);
      ctrl.ctrl.ready     = 1'b1;
      ctrl.ctrl.wrap      = (idx == WRAP_IDX);
      f_len[k]  = len;
      f_ptr[k]  = $random(seed);
      f_ctrl[k] = ctrl;
      f_idx[k]  = idx;
      if (ctrl.ctrl.irq_en) begin
        exp_irq++;
      end
      // DUT polls a BD that is not ready yet
      gap     = $unsigned($random(seed)) % 8;
      hold_en = (k % 4 == 3);
      repeat (gap) @(negedge clk);
      if (hold_en) begin
        tx_en = 1'b0;
      end
      @(posedge clk);
      desc_mem[{idx, 1'b1}] = f_ptr[k];
      desc_mem[{idx, 1'b0}] = ctrl.raw;
      @(negedge clk);
      if (hold_en) begin
        repeat (4 + gap) @(negedge clk);
        tx_en = 1'b1;
      end
      armed = 1'b1;
      while (done_count <= k) begin
        @(negedge clk);
      end
      armed = 1'b0;
      idx   = ctrl.ctrl.wrap ? bd_num_t'(0) : idx + bd_num_t'(1);
    end

    repeat (4) @(negedge clk);
    check_equal("irq_count", exp_irq, irq_seen);
    if (u_eth_tx_dma_top.u_eth_tx_dma_assertions.fail_count == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      stop_with_failure("a bound protocol assertion failed");
    end
  end

endmodule

// ==== eth_dma_params.svh ====
`ifndef ETH_DMA_PARAMS_SVH
`define ETH_DMA_PARAMS_SVH

// External memory and AXI read channel
`define ETH_AXI_ADDR_W 32
`define ETH_AXI_DATA_W 32
`define ETH_AXI_LEN_W 8

// Local memories
`define ETH_BUFFER_W 11
`define ETH_BD_ADDR_W 8

// Longest read burst in single-byte beats
`define ETH_MAX_BURST 16

// Pre-frame placed ahead of every payload
`define ETH_PREAMBLE_LEN 7
`define ETH_PREAMBLE 8'h55
`define ETH_SFD 8'hD5
`define ETH_PRE_FRAME_LEN 8

`endif

// ==== flist.f ====
+incdir+.
source/eth_dma_pkg.sv
source/tx_job_if.sv
source/tx_bd_sequencer.sv
source/tx_axi_burst_reader.sv
source/tx_frame_writer.sv
source/eth_tx_dma_top.sv
dv/eth_tx_dma_assertions.sv
dv/tb_eth_tx_dma.sv

// ==== source/eth_dma_pkg.sv ====
`include "eth_dma_params.svh"

package eth_dma_pkg;

  // Control and status word, found at the even BD address
  typedef struct packed {
    logic [15:0] frame_len;
    logic        ready;
    logic        irq_en;
    logic        wrap;
    logic        rsvd_12;
    logic        crc_en;
    logic [10:0] rsvd_low;
  } bd_ctrl_t;

  // One descriptor word, either control or buffer pointer
  typedef union packed {
    bd_ctrl_t    ctrl;
    logic [31:0] raw;
  } bd_word_u;

  // Two memory words per descriptor
  typedef logic [`ETH_BD_ADDR_W-2:0] bd_num_t;

endpackage

// ==== source/eth_tx_dma_top.sv ====
`timescale 1ns/1ps

`include "eth_dma_params.svh"

module eth_tx_dma_top (
  input  logic                       clk_i,
  input  logic                       arst_i,
  // Descriptor memory
  output logic [`ETH_BD_ADDR_W-1:0]  bd_addr_o,
  output logic                       bd_wen_o,
  output logic [31:0]                bd_wdata_o,
  input  logic [31:0]                bd_rdata_i,
  // AXI read channel
  output logic [`ETH_AXI_ADDR_W-1:0] axi_araddr_o,
  output logic [`ETH_AXI_LEN_W-1:0]  axi_arlen_o,
  output logic                       axi_arvalid_o,
  input  logic                       axi_arready_i,
  input  logic [`ETH_AXI_DATA_W-1:0] axi_rdata_i,
  input  logic                       axi_rvalid_i,
  input  logic                       axi_rlast_i,
  output logic                       axi_rready_o,
  // Frame buffer
  output logic                       buf_wen_o,
  output logic [`ETH_BUFFER_W-1:0]   buf_addr_o,
  output logic [7:0]                 buf_wdata_o,
  // Transmitter
  output logic                       send_o,
  output logic                       crc_en_o,
  output logic [10:0]                tx_nbytes_o,
  input  logic                       tx_ready_i,
  input  logic                       tx_en_i,
  output logic                       tx_irq_o
);

  logic                     init_done;
  logic                     pay_wen;
  logic [`ETH_BUFFER_W-1:0] pay_offset;
  logic [7:0]               pay_wdata;

  tx_job_if u_job ();

  tx_bd_sequencer u_tx_bd_sequencer (
    .clk_i       (clk_i),
    .arst_i      (arst_i),
    .tx_en_i     (tx_en_i),
    .tx_ready_i  (tx_ready_i),
    .init_done_i (init_done),
    .bd_addr_o   (bd_addr_o),
    .bd_wen_o    (bd_wen_o),
    .bd_wdata_o  (bd_wdata_o),
    .bd_rdata_i  (bd_rdata_i),
    .send_o      (send_o),
    .crc_en_o    (crc_en_o),
    .tx_nbytes_o (tx_nbytes_o),
    .tx_irq_o    (tx_irq_o),
    .job         (u_job.seq)
  );

  tx_axi_burst_reader u_tx_axi_burst_reader (
    .clk_i         (clk_i),
    .arst_i        (arst_i),
    .job           (u_job.rdr),
    .axi_araddr_o  (axi_araddr_o),
    .axi_arlen_o   (axi_arlen_o),
    .axi_arvalid_o (axi_arvalid_o),
    .axi_arready_i (axi_arready_i),
    .axi_rdata_i   (axi_rdata_i),
    .axi_rvalid_i  (axi_rvalid_i),
    .axi_rlast_i   (axi_rlast_i),
    .axi_rready_o  (axi_rready_o),
    .pay_wen_o     (pay_wen),
    .pay_offset_o  (pay_offset),
    .pay_wdata_o   (pay_wdata)
  );

  tx_frame_writer u_tx_frame_writer (
    .clk_i        (clk_i),
    .arst_i       (arst_i),
    .pay_wen_i    (pay_wen),
    .pay_offset_i (pay_offset),
    .pay_wdata_i  (pay_wdata),
    .init_done_o  (init_done),
    .buf_wen_o    (buf_wen_o),
    .buf_addr_o   (buf_addr_o),
    .buf_wdata_o  (buf_wdata_o)
  );

endmodule

// ==== source/tx_axi_burst_reader.sv ====
`timescale 1ns/1ps

`include "eth_dma_params.svh"

module tx_axi_burst_reader (
  input  logic                       clk_i,
  input  logic                       arst_i,
  tx_job_if.rdr                      job,
  output logic [`ETH_AXI_ADDR_W-1:0] axi_araddr_o,
  output logic [`ETH_AXI_LEN_W-1:0]  axi_arlen_o,
  output logic                       axi_arvalid_o,
  input  logic                       axi_arready_i,
  input  logic [`ETH_AXI_DATA_W-1:0] axi_rdata_i,
  input  logic                       axi_rvalid_i,
  input  logic                       axi_rlast_i,
  output logic                       axi_rready_o,
  output logic                       pay_wen_o,
  output logic [`ETH_BUFFER_W-1:0]   pay_offset_o,
  output logic [7:0]                 pay_wdata_o
);

  localparam int ADDR_W = `ETH_AXI_ADDR_W;
  localparam int LEN_W  = `ETH_AXI_LEN_W;
  localparam int LANE_W = $clog2(`ETH_AXI_DATA_W / 8);

  localparam logic [1:0] R_IDLE = 2'd0;
  localparam logic [1:0] R_ADDR = 2'd1;
  localparam logic [1:0] R_DATA = 2'd2;

  logic [1:0]        state_q;
  logic [15:0]       cnt_q;
  logic [15:0]       remaining;
  logic [15:0]       burst_beats;
  logic [LANE_W-1:0] lane;
  logic              beat;

  assign remaining   = job.frame_len - cnt_q;
  assign burst_beats = (remaining > 16'(`ETH_MAX_BURST)) ? 16'(`ETH_MAX_BURST) : remaining;

  // Address phase
  assign axi_araddr_o  = job.buf_ptr + ADDR_W'(cnt_q);
  assign axi_arlen_o   = LEN_W'(burst_beats - 16'd1);
  assign axi_arvalid_o = (state_q == R_ADDR) && (remaining != '0);

  // All bytes fetched, no further burst
  assign job.done = (state_q == R_ADDR) && (remaining == '0);

  // Data phase, one byte per beat in its own lane
  assign axi_rready_o = (state_q == R_DATA);
  assign beat         = axi_rready_o && axi_rvalid_i;
  assign lane         = axi_araddr_o[LANE_W-1:0];

  assign pay_wen_o    = beat;
  assign pay_offset_o = cnt_q[`ETH_BUFFER_W-1:0];
  assign pay_wdata_o  = axi_rdata_i[lane*8 +: 8];

  always_ff @(posedge clk_i) begin
    if (arst_i) begin
      state_q <= R_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        R_IDLE: begin
          if (job.start) begin
            cnt_q   <= '0;
            state_q <= R_ADDR;
          end
        end
        R_ADDR: begin
          if (remaining == '0) begin
            state_q <= R_IDLE;
          end else if (axi_arready_i) begin
            state_q <= R_DATA;
          end
        end
        R_DATA: begin
          if (beat) begin
            cnt_q <= cnt_q + 16'd1;
            // Next burst or done is decided back in the address phase
            if (axi_rlast_i) begin
              state_q <= R_ADDR;
            end
          end
        end
        default: state_q <= R_IDLE;
      endcase
    end
  end

endmodule

// ==== source/tx_bd_sequencer.sv ====
`timescale 1ns/1ps

`include "eth_dma_params.svh"

module tx_bd_sequencer (
  input  logic                      clk_i,
  input  logic                      arst_i,
  input  logic                      tx_en_i,
  input  logic                      tx_ready_i,
  input  logic                      init_done_i,
  output logic [`ETH_BD_ADDR_W-1:0] bd_addr_o,
  output logic                      bd_wen_o,
  output eth_dma_pkg::bd_word_u     bd_wdata_o,
  input  eth_dma_pkg::bd_word_u     bd_rdata_i,
  output logic                      send_o,
  output logic                      crc_en_o,
  output logic [10:0]               tx_nbytes_o,
  output logic                      tx_irq_o,
  tx_job_if.seq                     job
);

  import eth_dma_pkg::*;

  localparam logic [3:0] S_INIT     = 4'd0;
  localparam logic [3:0] S_CTRL_REQ = 4'd1;
  localparam logic [3:0] S_CTRL_RD  = 4'd2;
  localparam logic [3:0] S_PTR_REQ  = 4'd3;
  localparam logic [3:0] S_PTR_RD   = 4'd4;
  localparam logic [3:0] S_WAIT_TX  = 4'd5;
  localparam logic [3:0] S_BUSY     = 4'd6;
  localparam logic [3:0] S_SEND     = 4'd7;
  localparam logic [3:0] S_STATUS   = 4'd8;

  logic [3:0]                 state_q;
  bd_num_t                    bd_num_q;
  bd_word_u                   ctrl_q;
  logic [`ETH_AXI_ADDR_W-1:0] ptr_q;
  logic                       send_q;
  logic                       crc_en_q;
  logic [10:0]                nbytes_q;
  bd_word_u                   status;
  logic                       last_bd;

  // Ring wraps on the wrap bit or at the last index
  assign last_bd = ctrl_q.ctrl.wrap || (&bd_num_q);

  always_ff @(posedge clk_i) begin
    if (arst_i) begin
      state_q  <= S_INIT;
      bd_num_q <= '0;
      send_q   <= 1'b0;
      crc_en_q <= 1'b0;
      nbytes_q <= '0;
    end else begin
      case (state_q)
        S_INIT: begin
          if (init_done_i) begin
            state_q <= S_CTRL_REQ;
          end
        end
        S_CTRL_REQ: state_q <= S_CTRL_RD;
        S_CTRL_RD: begin
          // Poll until the BD is ready and transmission is enabled
          if (bd_rdata_i.ctrl.ready && tx_en_i) begin
            state_q <= S_PTR_REQ;
          end else begin
            state_q <= S_CTRL_REQ;
          end
        end
        S_PTR_REQ: state_q <= S_PTR_RD;
        S_PTR_RD:  state_q <= S_WAIT_TX;
        S_WAIT_TX: begin
          if (tx_ready_i) begin
            state_q <= S_BUSY;
          end
        end
        S_BUSY: begin
          if (job.done) begin
            send_q   <= 1'b1;
            crc_en_q <= ctrl_q.ctrl.crc_en;
            nbytes_q <= ctrl_q.ctrl.frame_len[10:0] + 11'(`ETH_PRE_FRAME_LEN);
            state_q  <= S_SEND;
          end
        end
        S_SEND: begin
          // Transmitter drops ready once it has taken the frame
          if (!tx_ready_i) begin
            send_q  <= 1'b0;
            state_q <= S_STATUS;
          end
        end
        S_STATUS: begin
          bd_num_q <= last_bd ? '0 : bd_num_q + bd_num_t'(1);
          state_q  <= S_CTRL_REQ;
        end
        default: state_q <= S_INIT;
      endcase
    end
  end

  // Descriptor words, captured one cycle after their address
  always_ff @(posedge clk_i) begin
    if (state_q == S_CTRL_RD) begin
      ctrl_q <= bd_rdata_i;
    end
    if (state_q == S_PTR_RD) begin
      ptr_q <= bd_rdata_i.raw;
    end
  end

  always_comb begin
    case (state_q)
      S_CTRL_REQ: bd_addr_o = {bd_num_q, 1'b0};
      S_PTR_REQ:  bd_addr_o = {bd_num_q, 1'b1};
      S_STATUS:   bd_addr_o = {bd_num_q, 1'b0};
      default:    bd_addr_o = '0;
    endcase
  end

  // Status is the control word with ready cleared
  always_comb begin
    status            = ctrl_q;
    status.ctrl.ready = 1'b0;
  end

  assign bd_wen_o    = (state_q == S_STATUS);
  assign bd_wdata_o  = status;
  assign tx_irq_o    = (state_q == S_STATUS) && ctrl_q.ctrl.irq_en;

  assign send_o      = send_q;
  assign crc_en_o    = crc_en_q;
  assign tx_nbytes_o = nbytes_q;

  assign job.start     = (state_q == S_WAIT_TX) && tx_ready_i;
  assign job.buf_ptr   = ptr_q;
  assign job.frame_len = ctrl_q.ctrl.frame_len;

endmodule

// ==== source/tx_frame_writer.sv ====
`timescale 1ns/1ps

`include "eth_dma_params.svh"

module tx_frame_writer (
  input  logic                     clk_i,
  input  logic                     arst_i,
  input  logic                     pay_wen_i,
  input  logic [`ETH_BUFFER_W-1:0] pay_offset_i,
  input  logic [7:0]               pay_wdata_i,
  output logic                     init_done_o,
  output logic                     buf_wen_o,
  output logic [`ETH_BUFFER_W-1:0] buf_addr_o,
  output logic [7:0]               buf_wdata_o
);

  localparam int BUF_W   = `ETH_BUFFER_W;
  localparam int PRE_LEN = `ETH_PRE_FRAME_LEN;
  localparam int CNT_W   = $clog2(PRE_LEN + 1);

  logic [CNT_W-1:0] pre_cnt_q;
  logic             pre_busy;

  assign pre_busy    = (pre_cnt_q != CNT_W'(PRE_LEN));
  assign init_done_o = !pre_busy;

  always_ff @(posedge clk_i) begin
    if (arst_i) begin
      pre_cnt_q <= '0;
      buf_wen_o <= 1'b0;
    end else if (pre_busy) begin
      pre_cnt_q <= pre_cnt_q + CNT_W'(1);
      buf_wen_o <= 1'b1;
    end else begin
      buf_wen_o <= pay_wen_i;
    end
  end

  // Preamble bytes then SFD, afterwards payload behind the pre-frame
  always_ff @(posedge clk_i) begin
    if (pre_busy) begin
      buf_addr_o  <= BUF_W'(pre_cnt_q);
      buf_wdata_o <= (pre_cnt_q == CNT_W'(`ETH_PREAMBLE_LEN)) ? `ETH_SFD : `ETH_PREAMBLE;
    end else begin
      buf_addr_o  <= pay_offset_i + BUF_W'(PRE_LEN);
      buf_wdata_o <= pay_wdata_i;
    end
  end

endmodule

// ==== source/tx_job_if.sv ====
`timescale 1ns/1ps

`include "eth_dma_params.svh"

// One frame fetch, handed from the BD sequencer to the burst reader
interface tx_job_if;

  logic                       start;
  logic [`ETH_AXI_ADDR_W-1:0] buf_ptr;
  logic [15:0]                frame_len;
  logic                       done;

  modport seq (
    output start,
    output buf_ptr,
    output frame_len,
    input  done
  );

  modport rdr (
    input  start,
    input  buf_ptr,
    input  frame_len,
    output done
  );

endinterface
